/* Bender.yml */
package:
  name: rename_freelist

sources:
  # Design
  - files:
      - src/rename_pkg.sv
      - src/rob_recovery_fsm.sv
      - src/walk_counter.sv
      - src/freelist.sv
      - src/rename_top.sv

  # Testbench
  - target: simulation
    files:
      - tb/rename_asserts.sv
      - tb/tb_rename.sv

/* filelist.f */
src/rename_pkg.sv
src/rob_recovery_fsm.sv
src/walk_counter.sv
src/freelist.sv
src/rename_top.sv
tb/rename_asserts.sv
tb/tb_rename.sv

/* src/freelist.sv */
`default_nettype none

module freelist import rename_pkg::*; #(
    parameter int NUM_PREGS = rename_pkg::NUM_PREGS  // Power of two, at most 32
) (
    input  wire        clock,
    input  wire        reset_n,
    input  wire        alloc0_valid,
    input  wire        alloc1_valid,      // Only with alloc0
    input  wire        commit0_valid,
    input  wire        commit1_valid,     // Only with commit0
    input  preg_idx_t  commit0_old_preg,
    input  preg_idx_t  commit1_old_preg,
    input  rob_state_e rob_state,
    input  walk_step_t walk_step,
    output preg_idx_t  alloc0_preg,
    output preg_idx_t  alloc1_preg,
    output fl_count_t  free_count,
    output logic       can_alloc
);

    // Pointers wrap modulo the depth through this mask
    localparam fl_ptr_t PTR_MASK  = fl_ptr_t'(NUM_PREGS - 1);
    localparam int      FREE_BASE = 32;  // First register not mapped at reset

    preg_idx_t entries [NUM_PREGS];

    fl_ptr_t tail;        // Next slot to fill on commit
    fl_ptr_t spec_head;   // Next entry handed to rename
    fl_ptr_t arch_head;   // Spec head as of the last commit
    logic    full;        // Tells 32 free apart from 0 when head == tail

    fl_ptr_t    head_p1;
    fl_ptr_t    slot1;
    fl_ptr_t    tail_next;
    fl_ptr_t    head_next;
    fl_ptr_t    arch_next;
    fl_ptr_t    ptr_diff;
    logic [1:0] alloc_cnt;
    logic [1:0] commit_cnt;
    logic [1:0] head_adv;
    logic       full_next;

    assign alloc_cnt  = {1'b0, alloc0_valid} + {1'b0, alloc1_valid};
    assign commit_cnt = {1'b0, commit0_valid} + {1'b0, commit1_valid};

    assign head_p1   = (spec_head + fl_ptr_t'(1)) & PTR_MASK;
    assign slot1     = (tail + fl_ptr_t'(commit0_valid)) & PTR_MASK;  // Slot after port 0
    assign tail_next = (tail + fl_ptr_t'(commit_cnt)) & PTR_MASK;
    assign arch_next = (arch_head + fl_ptr_t'(commit_cnt)) & PTR_MASK;  // One per commit

    // Spec head source, overwrite beats walk beats alloc
    always_comb begin
        head_adv = 2'd0;
        unique case (rob_state)
            ST_WALKING: head_adv = walk_step;
            ST_IDLE:    head_adv = alloc_cnt;
            default:    head_adv = 2'd0;
        endcase
        if (rob_state == ST_OVERWRITE_RAT) begin
            head_next = arch_head;
        end else begin
            head_next = (spec_head + fl_ptr_t'(head_adv)) & PTR_MASK;
        end
    end

    // Full only when pointers meet and the tail caught up with the head
    always_comb begin
        if (rob_state == ST_OVERWRITE_RAT) begin
            full_next = (arch_head == tail_next);  // Committed state keeps the queue full
        end else begin
            full_next = (head_next == tail_next) &&
                        ((commit_cnt != 2'd0) || ((head_adv == 2'd0) && full));
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            tail      <= '0;
            spec_head <= '0;
            arch_head <= '0;
            full      <= 1'b1;  // All entries free
        end else begin
            tail      <= tail_next;
            spec_head <= head_next;
            arch_head <= arch_next;
            full      <= full_next;
        end
    end

    // Commit writes, port 1 lands after port 0
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                entries[i] <= preg_idx_t'(i + FREE_BASE);  // Registers 32 and up start free
            end
        end else begin
            if (commit0_valid) begin
                entries[tail] <= commit0_old_preg;
            end
            if (commit1_valid) begin
                entries[slot1] <= commit1_old_preg;
            end
        end
    end

    // Same-cycle read at the head
    assign alloc0_preg = entries[spec_head];
    assign alloc1_preg = entries[head_p1];

    assign ptr_diff   = (tail - spec_head) & PTR_MASK;
    assign free_count = full ? fl_count_t'(NUM_PREGS) : fl_count_t'(ptr_diff);
    assign can_alloc  = (free_count >= fl_count_t'(2)) && (rob_state == ST_IDLE);

endmodule

`default_nettype wire

/* src/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // Default free list depth, the top level passes it down as a parameter
    localparam int NUM_PREGS = 32;

    typedef logic [5:0] preg_idx_t;   // Physical register index, 0..63
    typedef logic [4:0] fl_ptr_t;     // Queue pointer, wraps modulo depth
    typedef logic [5:0] fl_count_t;   // Free entries, 0..32
    typedef logic [4:0] walk_len_t;   // Surviving uncommitted instructions
    typedef logic [1:0] walk_step_t;  // Head advance per walk cycle, 0..2

    // Recovery sequence after a mispredict
    typedef enum logic [1:0] {
        ST_IDLE          = 2'd0,  // Normal rename
        ST_OVERWRITE_RAT = 2'd1,  // Spec head <= arch head
        ST_WALKING       = 2'd2   // Replay surviving allocations
    } rob_state_e;

endpackage

`default_nettype wire

/* src/rename_top.sv */
`default_nettype none

module rename_top import rename_pkg::*; #(
    parameter int NUM_PREGS = rename_pkg::NUM_PREGS
) (
    input  wire       clock,
    input  wire       reset_n,
    // Rename side
    input  wire       alloc0_valid,
    input  wire       alloc1_valid,
    output preg_idx_t alloc0_preg,
    output preg_idx_t alloc1_preg,
    output fl_count_t free_count,
    output logic      can_alloc,
    // Commit side, old mappings coming back
    input  wire       commit0_valid,
    input  preg_idx_t commit0_old_preg,
    input  wire       commit1_valid,
    input  preg_idx_t commit1_old_preg,
    // Mispredict recovery
    input  wire       recover_valid,
    input  walk_len_t recover_len,
    output logic      recovery_busy
);

    rob_state_e rob_state;
    walk_step_t walk_step;
    logic       walk_done;

    rob_recovery_fsm u_rob_recovery_fsm (
        .clock         (clock),
        .reset_n       (reset_n),
        .recover_valid (recover_valid),
        .walk_done     (walk_done),
        .rob_state     (rob_state),
        .recovery_busy (recovery_busy)
    );

    walk_counter u_walk_counter (
        .clock         (clock),
        .reset_n       (reset_n),
        .recover_valid (recover_valid),
        .recover_len   (recover_len),
        .rob_state     (rob_state),
        .walk_step     (walk_step),
        .walk_done     (walk_done)
    );

    freelist #(
        .NUM_PREGS (NUM_PREGS)
    ) u_freelist (
        .clock            (clock),
        .reset_n          (reset_n),
        .alloc0_valid     (alloc0_valid),
        .alloc1_valid     (alloc1_valid),
        .commit0_valid    (commit0_valid),
        .commit1_valid    (commit1_valid),
        .commit0_old_preg (commit0_old_preg),
        .commit1_old_preg (commit1_old_preg),
        .rob_state        (rob_state),
        .walk_step        (walk_step),
        .alloc0_preg      (alloc0_preg),
        .alloc1_preg      (alloc1_preg),
        .free_count       (free_count),
        .can_alloc        (can_alloc)
    );

endmodule

`default_nettype wire

/* src/rob_recovery_fsm.sv */
`default_nettype none

module rob_recovery_fsm import rename_pkg::*; (
    input  wire        clock,
    input  wire        reset_n,
    input  wire        recover_valid,  // Mispredict strobe
    input  wire        walk_done,      // Last walking cycle
    output rob_state_e rob_state,
    output logic       recovery_busy
);

    rob_state_e state_q;
    rob_state_e state_d;

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (recover_valid) begin
                    state_d = ST_OVERWRITE_RAT;
                end
            end
            ST_OVERWRITE_RAT: begin
                // Always one walking cycle, even for a zero length
                state_d = ST_WALKING;
            end
            ST_WALKING: begin
                if (walk_done) begin
                    state_d = ST_IDLE;  // Remainder used up
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign rob_state     = state_q;
    assign recovery_busy = (state_q != ST_IDLE);  // Blocks alloc, commit, recover

endmodule

`default_nettype wire

/* src/walk_counter.sv */
`default_nettype none

module walk_counter import rename_pkg::*; (
    input  wire        clock,
    input  wire        reset_n,
    input  wire        recover_valid,
    input  walk_len_t  recover_len,   // Survivors to replay
    input  rob_state_e rob_state,
    output walk_step_t walk_step,     // Spec head advance this cycle
    output logic       walk_done
);

    walk_len_t remain;     // Survivors not yet walked
    logic      walking;

    assign walking = (rob_state == ST_WALKING);

    // Up to two per cycle, nothing outside the walk
    always_comb begin
        walk_step = 2'd0;
        if (walking) begin
            walk_step = (remain >= walk_len_t'(2)) ? walk_step_t'(2) : walk_step_t'(remain);
        end
    end

    // Zero remainder or this step drains it
    assign walk_done = walking && (remain <= walk_len_t'(2));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            remain <= '0;
        end else if (recover_valid && (rob_state == ST_IDLE)) begin
            remain <= recover_len;  // Loaded one cycle before OVERWRITE_RAT ends
        end else if (walking) begin
            remain <= remain - walk_len_t'(walk_step);
        end
    end

endmodule

`default_nettype wire

/* tb/rename_asserts.sv */
`default_nettype none

module rename_asserts import rename_pkg::*; (
    input  wire       clock,
    input  wire       reset_n,
    input  wire       alloc0_valid,
    input  wire       alloc1_valid,
    input  wire       commit0_valid,
    input  wire       commit1_valid,
    input  wire       recover_valid,
    input  wire       can_alloc,
    input  wire       recovery_busy,
    input  fl_count_t free_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // No stall path, so rename must respect can_alloc
    alloc_needs_room: assert property (@(posedge clock) disable iff (!reset_n)
        alloc0_valid |-> can_alloc)
        else $error("alloc strobe while can_alloc is low");

    alloc1_with_alloc0: assert property (@(posedge clock) disable iff (!reset_n)
        alloc1_valid |-> alloc0_valid)
        else $error("alloc1 strobe without alloc0");

    commit1_with_commit0: assert property (@(posedge clock) disable iff (!reset_n)
        commit1_valid |-> commit0_valid)
        else $error("commit1 strobe without commit0");

    // Commit and recover wait for the walk to finish
    commit_when_idle: assert property (@(posedge clock) disable iff (!reset_n)
        commit0_valid |-> !recovery_busy)
        else $error("commit strobe during recovery");

    recover_when_idle: assert property (@(posedge clock) disable iff (!reset_n)
        recover_valid |-> !recovery_busy)
        else $error("recover strobe during recovery");

    // Outside recovery the count moves only by allocs and commits
    count_tracks_strobes: assert property (@(posedge clock) disable iff (!reset_n)
        (!recovery_busy && !$past(recovery_busy)) |->
        (free_count == $past(free_count)
                      - fl_count_t'($past(alloc0_valid))
                      - fl_count_t'($past(alloc1_valid))
                      + fl_count_t'($past(commit0_valid))
                      + fl_count_t'($past(commit1_valid))))
        else $error("free_count does not follow the alloc and commit strobes");

endmodule

`default_nettype wire

/* tb/tb_rename.sv */
`default_nettype none

module tb_rename import rename_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    logic      clock;
    logic      reset_n;
    logic      alloc0_valid;
    logic      alloc1_valid;
    preg_idx_t alloc0_preg;
    preg_idx_t alloc1_preg;
    fl_count_t free_count;
    logic      can_alloc;
    logic      commit0_valid;
    preg_idx_t commit0_old_preg;
    logic      commit1_valid;
    preg_idx_t commit1_old_preg;
    logic      recover_valid;
    walk_len_t recover_len;
    logic      recovery_busy;

    // Free list model, pointers never wrap so full and empty stay apart
    int model_q [32];
    int m_tail;
    int m_head;   // Speculative head
    int m_arch;   // Architectural head
    int checks;
    int errors;

    rename_top #(
        .NUM_PREGS (32)
    ) u_rename_top (
        .clock            (clock),
        .reset_n          (reset_n),
        .alloc0_valid     (alloc0_valid),
        .alloc1_valid     (alloc1_valid),
        .alloc0_preg      (alloc0_preg),
        .alloc1_preg      (alloc1_preg),
        .free_count       (free_count),
        .can_alloc        (can_alloc),
        .commit0_valid    (commit0_valid),
        .commit0_old_preg (commit0_old_preg),
        .commit1_valid    (commit1_valid),
        .commit1_old_preg (commit1_old_preg),
        .recover_valid    (recover_valid),
        .recover_len      (recover_len),
        .recovery_busy    (recovery_busy)
    );

    bind rename_top rename_asserts u_rename_asserts (
        .clock         (clock),
        .reset_n       (reset_n),
        .alloc0_valid  (alloc0_valid),
        .alloc1_valid  (alloc1_valid),
        .commit0_valid (commit0_valid),
        .commit1_valid (commit1_valid),
        .recover_valid (recover_valid),
        .can_alloc     (can_alloc),
        .recovery_busy (recovery_busy),
        .free_count    (free_count)
    );

    always #4 clock = ~clock;  // 8 ns period

    task automatic compare(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Idle state against the model
    task automatic check_state();
        int cnt;
        cnt = m_tail - m_head;
        compare("free_count", free_count, cnt);
        compare("can_alloc", can_alloc, (cnt >= 2));
        compare("recovery_busy", recovery_busy, 0);
    endtask

    task automatic alloc_regs(input int n);
        @(negedge clock);
        alloc0_valid = 1'b1;
        alloc1_valid = (n == 2);
        #1;  // Combinational read at the head
        compare("alloc0_preg", alloc0_preg, model_q[m_head % 32]);
        if (n == 2) begin
            compare("alloc1_preg", alloc1_preg, model_q[(m_head + 1) % 32]);
        end
        m_head += n;
        @(negedge clock);
        alloc0_valid = 1'b0;
        alloc1_valid = 1'b0;
        check_state();
    endtask

    task automatic commit_regs(input int n);
        int v0;
        int v1;
        v0 = $urandom % 64;
        v1 = $urandom % 64;
        @(negedge clock);
        commit0_valid    = 1'b1;
        commit0_old_preg = preg_idx_t'(v0);
        commit1_valid    = (n == 2);
        commit1_old_preg = preg_idx_t'(v1);
        model_q[m_tail % 32] = v0;
        if (n == 2) begin
            model_q[(m_tail + 1) % 32] = v1;  // Port 1 lands after port 0
        end
        m_tail += n;
        m_arch += n;  // One allocation retired per commit
        @(negedge clock);
        commit0_valid = 1'b0;
        commit1_valid = 1'b0;
        check_state();
    endtask

    // Strobe recovery, time the busy window, then check the restored head
    task automatic recover(input int len);
        int busy_cycles;
        int walk_cycles;
        busy_cycles = 0;
        walk_cycles = (len + 1) / 2;
        if (walk_cycles < 1) begin
            walk_cycles = 1;  // A zero length still walks once
        end
        @(negedge clock);
        recover_valid = 1'b1;
        recover_len   = walk_len_t'(len);
        @(negedge clock);
        recover_valid = 1'b0;
        recover_len   = '0;
        while (recovery_busy && busy_cycles < 64) begin
            busy_cycles++;
            compare("can_alloc", can_alloc, 0);  // Blocked all through the walk
            @(negedge clock);
        end
        assert (!recovery_busy) else begin
            errors++;
            $display("Timeout: recovery_busy still high after 64 cycles at t=%0t", $time);
        end
        compare("recovery_busy cycles", busy_cycles, 1 + walk_cycles);
        m_head = m_arch + len;
        check_state();
        compare("alloc0_preg", alloc0_preg, model_q[m_head % 32]);
    endtask

    task automatic reset_values();
        check_state();
        compare("alloc0_preg", alloc0_preg, 32);
        compare("alloc1_preg", alloc1_preg, 33);
    endtask

    // Drain down to one entry so can_alloc drops
    task automatic fill_and_drain();
        repeat (15) alloc_regs(2);
        compare("can_alloc", can_alloc, 1);
        alloc_regs(1);
        compare("can_alloc", can_alloc, 0);
    endtask

    // Head wraps onto the freshly committed slots
    task automatic commit_and_wrap();
        repeat (5) commit_regs(2);
        commit_regs(1);
        alloc_regs(1);
        repeat (5) alloc_regs(2);
    endtask

    task automatic odd_length_recovery();
        repeat (4) commit_regs(2);
        repeat (2) alloc_regs(2);
        recover(3);
        alloc_regs(1);
    endtask

    task automatic busy_duration();
        int lens [4];
        lens = '{0, 1, 4, 7};
        foreach (lens[i]) begin
            repeat (4) alloc_regs(2);  // Enough uncommitted work to walk
            recover(lens[i]);
        end
    endtask

    initial begin
        clock            = 1'b0;
        reset_n          = 1'b0;
        alloc0_valid     = 1'b0;
        alloc1_valid     = 1'b0;
        commit0_valid    = 1'b0;
        commit0_old_preg = '0;
        commit1_valid    = 1'b0;
        commit1_old_preg = '0;
        recover_valid    = 1'b0;
        recover_len      = '0;
        checks           = 0;
        errors           = 0;
        void'($urandom(32'h8cb2));
        for (int i = 0; i < 32; i++) begin
            model_q[i] = 32 + i;
        end
        m_tail = 32;  // Queue starts full
        m_head = 0;
        m_arch = 0;
        repeat (5) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);

        reset_values();
        fill_and_drain();
        commit_and_wrap();
        odd_length_recovery();
        busy_duration();

        repeat (2) @(negedge clock);
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
